// File: common/buzzerPkg.sv
`default_nettype none

package buzzerPkg;

	typedef logic [31:0] busAddr;
	typedef logic [31:0] busData;
	typedef logic [15:0] noteWord;  // beat in 11:8 and tune in 7:0
	typedef logic [7:0]  tuneIdx;   // zero is a rest
	typedef logic [3:0]  beatCode;  // zero ends the score
	typedef logic [3:0]  regOffset;
	typedef logic [1:0]  transCode;

	typedef enum logic [2:0] {
		stIdle,
		stRequest,
		stWaitNote,
		stPlay,
		stDone
	} voiceState;

	// register map
	localparam regOffset regCtrl     = 4'h0;
	localparam regOffset regBgmStart = 4'h4;
	localparam regOffset regSfxStart = 4'h8;
	localparam regOffset regStatus   = 4'hC;

	// control bits
	localparam int bitBgmPlay   = 0;
	localparam int bitCyclic    = 1;
	localparam int bitBgmStop   = 2;
	localparam int bitSfxPlay   = 3;

	// status bits
	localparam int bitBgmPlaying = 0;
	localparam int bitSfxPlaying = 1;

	localparam transCode transIdle   = 2'd0;
	localparam transCode transNonSeq = 2'd2;

endpackage

`default_nettype wire

// File: common/noteFetchIf.sv
`timescale 1ns/1ps
`default_nettype none

interface noteFetchIf
	import buzzerPkg::*;
();

	logic    req;   // one-cycle pulse
	busAddr  addr;  // stable until done
	logic    done;
	noteWord note;  // valid with done

	modport ctrl (
		output req,
		output addr,
		input  done,
		input  note
	);

	modport fetch (
		input  req,
		input  addr,
		output done,
		output note
	);

endinterface

`default_nettype wire

// File: common/toneIf.sv
`timescale 1ns/1ps
`default_nettype none

interface toneIf
	import buzzerPkg::*;
();

	logic    start;     // begins a note
	tuneIdx  tune;      // held for the whole note
	beatCode beat;
	logic    beatDone;

	modport ctrl (output start, output tune, output beat, input beatDone);

	modport gen (input start, input tune, input beat, output beatDone);

endinterface

`default_nettype wire

// File: src/buzzerRegs.sv
`timescale 1ns/1ps
`default_nettype none

module buzzerRegs
	import buzzerPkg::*;
(
	input  wire           clk,
	input  wire           rst_n,
	input  wire           HSEL,
	input  wire           HREADY,
	input  wire           HWRITE,
	input  wire transCode HTRANS,
	input  wire busAddr   HADDR,
	input  wire busData   HWDATA,
	input  wire           bgmFinished,
	input  wire           sfxFinished,
	output busData        HRDATA,
	output logic          HREADYOUT,
	output logic [1:0]    HRESP,
	output logic          playBgm,
	output logic          playSfx,
	output logic          cyclic,
	output logic          stopBgm,
	output busAddr        bgmStart,
	output busAddr        sfxStart
);

	logic     accept;
	logic     wrPend;      // write data phase in progress
	regOffset addrQ;
	logic     ctrlWr;
	logic     bgmPlaying;
	logic     sfxPlaying;

	assign accept = HSEL && HREADY && HTRANS == transNonSeq;
	assign ctrlWr = wrPend && addrQ == regCtrl;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// address phase

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wrPend <= 1'b0;
			addrQ  <= '0;
		end else if (HREADY) begin
			wrPend <= accept && HWRITE;
			if (accept)
				addrQ <= HADDR[3:0];
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// data phase

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cyclic   <= 1'b0;
			stopBgm  <= 1'b0;
			bgmStart <= '0;
			sfxStart <= '0;
		end else begin
			stopBgm <= ctrlWr && HWDATA[bitBgmStop];
			if (ctrlWr)
				cyclic <= HWDATA[bitCyclic];
			if (wrPend && addrQ == regBgmStart)
				bgmStart <= HWDATA;
			if (wrPend && addrQ == regSfxStart)
				sfxStart <= HWDATA;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bgmPlaying <= 1'b0;
			sfxPlaying <= 1'b0;
		end else begin
			if (ctrlWr && HWDATA[bitBgmStop])
				bgmPlaying <= 1'b0;      // stop wins over play
			else if (ctrlWr && HWDATA[bitBgmPlay])
				bgmPlaying <= 1'b1;
			else if (bgmFinished)
				bgmPlaying <= 1'b0;
			if (ctrlWr && HWDATA[bitSfxPlay])
				sfxPlaying <= 1'b1;
			else if (sfxFinished)
				sfxPlaying <= 1'b0;
		end
	end

	always_comb begin
		HRDATA = '0;
		case (addrQ)
			regCtrl: begin
				HRDATA[bitBgmPlay] = bgmPlaying;
				HRDATA[bitCyclic]  = cyclic;
				HRDATA[bitSfxPlay] = sfxPlaying;
			end
			regBgmStart: HRDATA = bgmStart;
			regSfxStart: HRDATA = sfxStart;
			regStatus: begin
				HRDATA[bitBgmPlaying] = bgmPlaying;
				HRDATA[bitSfxPlaying] = sfxPlaying;
			end
			default: HRDATA = '0;
		endcase
	end

	assign HREADYOUT = 1'b1;  // no wait states
	assign HRESP     = 2'b00;
	assign playBgm   = bgmPlaying;
	assign playSfx   = sfxPlaying;

endmodule

`default_nettype wire

// File: voice/voiceCtrl.sv
`timescale 1ns/1ps
`default_nettype none

module voiceCtrl
	import buzzerPkg::*;
(
	input  wire         clk,
	input  wire         rst_n,
	input  wire         play,
	input  wire         cyclic,
	input  wire         stop,
	input  wire busAddr startAddr,
	output logic        finished,
	noteFetchIf.ctrl    fetch,
	toneIf.ctrl         tone
);

	voiceState state;
	busAddr    addrCnt;   // address of the word being fetched or played
	noteWord   noteQ;
	logic      startQ;
	beatCode   nextBeat;

	assign nextBeat = fetch.note[11:8];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// score sequencer

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state   <= stIdle;
			addrCnt <= '0;
			startQ  <= 1'b0;
		end else begin
			// a stop also restarts toneGen with a zero beat to silence it
			startQ <= stop || (state == stWaitNote && fetch.done && nextBeat != '0);
			if (stop) begin
				state <= stIdle;
			end else begin
				case (state)
					stIdle: begin
						if (play) begin
							addrCnt <= startAddr;
							state   <= stRequest;
						end
					end
					stRequest: state <= stWaitNote;  // req pulses here
					stWaitNote: begin
						if (fetch.done) begin
							if (nextBeat != '0) begin
								state <= stPlay;
							end else if (cyclic) begin
								addrCnt <= startAddr;  // wrap the score
								state   <= stRequest;
							end else begin
								state <= stDone;
							end
						end
					end
					stPlay: begin
						if (tone.beatDone) begin
							addrCnt <= addrCnt + 32'd4;
							state   <= stRequest;
						end
					end
					stDone:  state <= stIdle;
					default: state <= stIdle;
				endcase
			end
		end
	end

	// current note word
	always_ff @(posedge clk) begin
		if (stop)
			noteQ[11:8] <= '0;
		else if (state == stWaitNote && fetch.done)
			noteQ <= fetch.note;
	end

	assign fetch.req  = state == stRequest;
	assign fetch.addr = addrCnt;
	assign tone.start = startQ;
	assign tone.tune  = noteQ[7:0];
	assign tone.beat  = noteQ[11:8];
	assign finished   = state == stDone;

endmodule

`default_nettype wire

// File: voice/noteFetch.sv
`timescale 1ns/1ps
`default_nettype none

module noteFetch
	import buzzerPkg::*;
(
	input  wire         clk,
	input  wire         rst_n,
	input  wire         HREADY,
	input  wire busData HRDATA,
	output busAddr      HADDR,
	output transCode    HTRANS,
	output logic        HWRITE,
	noteFetchIf.fetch   fetch
);

	logic    addrPhase;
	logic    dataPhase;
	logic    doneQ;
	noteWord noteQ;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			addrPhase <= 1'b0;
			dataPhase <= 1'b0;
			doneQ     <= 1'b0;
		end else begin
			addrPhase <= fetch.req;         // single NONSEQ cycle
			doneQ     <= dataPhase && HREADY;
			if (addrPhase)
				dataPhase <= 1'b1;
			else if (dataPhase && HREADY)
				dataPhase <= 1'b0;          // wait states hold it open
		end
	end

	always_ff @(posedge clk) begin
		if (dataPhase && HREADY)
			noteQ <= HRDATA[15:0];  // low half-word only
	end

	assign HADDR      = fetch.addr;
	assign HTRANS     = addrPhase ? transNonSeq : transIdle;
	assign HWRITE     = 1'b0;  // read only
	assign fetch.done = doneQ;
	assign fetch.note = noteQ;

endmodule

`default_nettype wire

// File: voice/toneGen.sv
`timescale 1ns/1ps
`default_nettype none

module toneGen #(
	parameter int beatUnit = 16,
	parameter int toneUnit = 4
) (
	input  wire  clk,
	input  wire  rst_n,
	output logic pwm,
	toneIf.gen   tone
);

	localparam int beatW = 4 + $clog2(beatUnit + 1);
	localparam int halfW = 8 + $clog2(toneUnit + 1);

	logic [beatW-1:0] beatLen;
	logic [beatW-1:0] beatCnt;
	logic [halfW-1:0] halfLen;
	logic [halfW-1:0] halfCnt;
	logic             active;   // note in progress
	logic             pwmQ;
	logic             beatEnd;

	assign beatLen = beatW'(tone.beat) * beatW'(beatUnit);
	assign halfLen = halfW'(tone.tune) * halfW'(toneUnit);
	assign beatEnd = active && beatCnt == '0;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// beat and half-period counters

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			active  <= 1'b0;
			beatCnt <= '0;
			halfCnt <= '0;
			pwmQ    <= 1'b0;
		end else if (tone.start) begin
			active  <= tone.beat != '0;  // zero beat just silences
			beatCnt <= beatLen - 1'b1;
			halfCnt <= halfLen - 1'b1;
			pwmQ    <= 1'b0;             // each note starts low
		end else if (active) begin
			if (beatEnd)
				active <= 1'b0;
			else
				beatCnt <= beatCnt - 1'b1;
			if (halfCnt == '0) begin
				halfCnt <= halfLen - 1'b1;
				pwmQ    <= pwmQ ^ (tone.tune != '0);  // rest never toggles
			end else begin
				halfCnt <= halfCnt - 1'b1;
			end
		end
	end

	assign tone.beatDone = beatEnd;
	assign pwm           = pwmQ && active;

endmodule

`default_nettype wire

// File: src/Buzzer.sv
`timescale 1ns/1ps
`default_nettype none

module Buzzer
	import buzzerPkg::*;
#(
	parameter int beatUnit = 16,
	parameter int toneUnit = 4
) (
	input  wire           clk,
	input  wire           rst_n,
	input  wire           HSEL,
	input  wire           HREADY,
	input  wire           HWRITE,
	input  wire transCode HTRANS,
	input  wire busAddr   HADDR,
	input  wire busData   HWDATA,
	output busData        HRDATA,
	output logic          HREADYOUT,
	output logic [1:0]    HRESP,
	output busAddr        bgmHADDR,
	output transCode      bgmHTRANS,
	output logic          bgmHWRITE,
	input  wire busData   bgmHRDATA,
	input  wire           bgmHREADY,
	output busAddr        sfxHADDR,
	output transCode      sfxHTRANS,
	output logic          sfxHWRITE,
	input  wire busData   sfxHRDATA,
	input  wire           sfxHREADY,
	output logic          PWM,
	output logic          BeatFinIRQ
);

	logic   playBgm;
	logic   playSfx;
	logic   cyclic;
	logic   stopBgm;
	busAddr bgmStart;
	busAddr sfxStart;
	logic   bgmFinished;
	logic   sfxFinished;
	logic   pwmBgm;
	logic   pwmSfx;

	noteFetchIf bgmFetch ();
	noteFetchIf sfxFetch ();
	toneIf      bgmTone ();
	toneIf      sfxTone ();

	buzzerRegs regs (
		.clk, .rst_n, .HSEL, .HREADY, .HWRITE, .HTRANS, .HADDR, .HWDATA,
		.bgmFinished, .sfxFinished, .HRDATA, .HREADYOUT, .HRESP,
		.playBgm, .playSfx, .cyclic, .stopBgm, .bgmStart, .sfxStart
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// background voice

	voiceCtrl bgmCtrl (
		.clk, .rst_n, .play(playBgm), .cyclic, .stop(stopBgm),
		.startAddr(bgmStart), .finished(bgmFinished), .fetch(bgmFetch), .tone(bgmTone)
	);

	noteFetch bgmFetcher (
		.clk, .rst_n, .HREADY(bgmHREADY), .HRDATA(bgmHRDATA),
		.HADDR(bgmHADDR), .HTRANS(bgmHTRANS), .HWRITE(bgmHWRITE), .fetch(bgmFetch)
	);

	toneGen #(.beatUnit(beatUnit), .toneUnit(toneUnit)) bgmGen (
		.clk, .rst_n, .pwm(pwmBgm), .tone(bgmTone)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// sound effect voice

	voiceCtrl sfxCtrl (
		.clk, .rst_n, .play(playSfx), .cyclic(1'b0), .stop(1'b0),
		.startAddr(sfxStart), .finished(sfxFinished), .fetch(sfxFetch), .tone(sfxTone)
	);

	noteFetch sfxFetcher (
		.clk, .rst_n, .HREADY(sfxHREADY), .HRDATA(sfxHRDATA),
		.HADDR(sfxHADDR), .HTRANS(sfxHTRANS), .HWRITE(sfxHWRITE), .fetch(sfxFetch)
	);

	toneGen #(.beatUnit(beatUnit), .toneUnit(toneUnit)) sfxGen (
		.clk, .rst_n, .pwm(pwmSfx), .tone(sfxTone)
	);

	// sound effect owns the pin while it plays
	assign PWM        = playSfx ? pwmSfx : pwmBgm;
	assign BeatFinIRQ = playSfx ? sfxTone.beatDone : bgmTone.beatDone;

endmodule

`default_nettype wire

// File: test/clockGen.sv
`timescale 1ns/1ps
`default_nettype none

module clockGen (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk   = 1'b0;
		rst_n = 1'b0;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;  // released after three cycles
	end

	always #10 clk = ~clk;  // 20 ns period

endmodule

`default_nettype wire

// File: test/buzzerChecker.sv
`timescale 1ns/1ps
`default_nettype none

module buzzerChecker
	import buzzerPkg::*;
#(
	parameter int beatUnit = 16,
	parameter int toneUnit = 4
) (
	input wire           clk,
	input wire           rst_n,
	input wire           HSEL,
	input wire           HWRITE,
	input wire transCode HTRANS,
	input wire busAddr   HADDR,
	input wire busData   HWDATA,
	input wire busAddr   bgmHADDR,
	input wire transCode bgmHTRANS,
	input wire           bgmHWRITE,
	input wire busData   bgmHRDATA,
	input wire           bgmHREADY,
	input wire busAddr   sfxHADDR,
	input wire transCode sfxHTRANS,
	input wire           sfxHWRITE,
	input wire busData   sfxHRDATA,
	input wire           sfxHREADY,
	input wire           PWM,
	input wire           BeatFinIRQ
);

	int       errCount = 0;
	int       testErrs = 0;
	int       testCount = 0;
	string    testName = "reset";
	int       cyc = 0;
	int       fetchCount [2] = '{0, 0};
	int       startHits = 0;     // bgm fetches of its start address
	busAddr   startAddr [2];
	busAddr   expAddr [2];
	logic     tracking [2] = '{1'b0, 1'b0};
	logic     inData [2] = '{1'b0, 1'b0};
	int       noteStart [2] = '{0, 0};
	int       noteLen [2] = '{0, 0};
	int       halfLen [2] = '{0, 0};
	logic     cyclicM = 1'b0;
	logic     bgmStopped = 1'b0;
	logic     sfxSel = 1'b0;
	int       sfxOnAt = -1;
	int       sfxOffAt = -1;
	logic     wrPend = 1'b0;
	regOffset wrOff;
	int       sel;

	task compareValue(input string what, input busData expected, input busData actual);
		if (expected !== actual) begin
			$display("mismatch %s %s: expected %h, actual %h", testName, what, expected, actual);
			errCount++;
		end
	endtask

	task beginTest(input string name);
		testName = name;
		testErrs = errCount;
	endtask

	task endTest();
		testCount++;
		if (errCount == testErrs)
			$display("test %s: ok", testName);
		else
			$display("test %s: failed with %0d errors", testName, errCount - testErrs);
	endtask

	// expected output of a voice in the current cycle
	function automatic logic expPwm(input int v);
		int t;
		t = cyc - noteStart[v];
		if (t < 1 || t > noteLen[v] || halfLen[v] == 0)
			return 1'b0;
		return ((t - 1) / halfLen[v]) % 2 == 1;
	endfunction

	function automatic logic expIrq(input int v);
		return noteLen[v] != 0 && cyc - noteStart[v] == noteLen[v];
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// per-voice fetch and note model

	task automatic stepVoice(input int v, input transCode tr, input busAddr a, input logic wr,
			input logic rdy, input busData rd);
		noteWord w;
		if (!tracking[v]) begin
			if (tr == transNonSeq && !(v == 0 && bgmStopped)) begin
				$display("%s: %s master fetched while its voice was idle", testName,
					v == 0 ? "bgm" : "sfx");
				errCount++;
			end
			return;
		end
		if (tr == transNonSeq) begin
			compareValue(v == 0 ? "bgm fetch address" : "sfx fetch address", expAddr[v], a);
			compareValue("fetch HWRITE", 32'd0, 32'(wr));
			fetchCount[v]++;
			if (v == 0 && a == startAddr[0])
				startHits++;
			inData[v] = 1'b1;
		end else if (inData[v] && rdy) begin
			inData[v] = 1'b0;
			w = rd[15:0];
			if (w[11:8] != 4'd0) begin
				noteStart[v] = cyc + 2;  // start two cycles after capture
				noteLen[v]   = int'(w[11:8]) * beatUnit;
				halfLen[v]   = int'(w[7:0]) * toneUnit;
				expAddr[v]   = expAddr[v] + 32'd4;
			end else if (v == 0 && cyclicM) begin
				expAddr[0] = startAddr[0];
			end else begin
				tracking[v] = 1'b0;
				if (v == 1)
					sfxOffAt = cyc + 3;
			end
		end
	endtask

	always @(negedge clk) begin
		if (rst_n) begin
			cyc++;
			if (cyc == sfxOnAt)
				sfxSel = 1'b1;
			if (cyc == sfxOffAt)
				sfxSel = 1'b0;
			if (wrPend) begin  // data phase of a register write
				if (wrOff == regBgmStart)
					startAddr[0] = HWDATA;
				if (wrOff == regSfxStart)
					startAddr[1] = HWDATA;
				if (wrOff == regCtrl) begin
					cyclicM = HWDATA[bitCyclic];
					if (HWDATA[bitBgmStop]) begin
						tracking[0] = 1'b0;
						bgmStopped  = 1'b1;
					end else if (HWDATA[bitBgmPlay] && !tracking[0]) begin
						tracking[0] = 1'b1;
						expAddr[0]  = startAddr[0];
					end
					if (HWDATA[bitSfxPlay] && !tracking[1]) begin
						tracking[1] = 1'b1;
						expAddr[1]  = startAddr[1];
						sfxOnAt     = cyc + 1;
					end
				end
			end
			wrPend = HSEL && HWRITE && HTRANS == transNonSeq;
			wrOff  = HADDR[3:0];
			stepVoice(0, bgmHTRANS, bgmHADDR, bgmHWRITE, bgmHREADY, bgmHRDATA);
			stepVoice(1, sfxHTRANS, sfxHADDR, sfxHWRITE, sfxHREADY, sfxHRDATA);
			sel = sfxSel ? 1 : 0;
			if (!(sel == 0 && bgmStopped)) begin
				compareValue("PWM", 32'(expPwm(sel)), 32'(PWM));
				compareValue("BeatFinIRQ", 32'(expIrq(sel)), 32'(BeatFinIRQ));
			end
		end
	end

endmodule

`default_nettype wire

// File: test/buzzerTb.sv
`timescale 1ns/1ps
`default_nettype none

module noteMemory
	import buzzerPkg::*;
(
	input  wire           clk,
	input  wire           rst_n,
	input  wire busAddr   HADDR,
	input  wire transCode HTRANS,
	output logic          HREADY,
	output busData        HRDATA
);

	noteWord     words [0:15];
	busAddr      addrQ;
	int unsigned waitLeft;
	int unsigned w;

	// bits 15:0 hold the note and the upper half is address junk
	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			HREADY   <= 1'b1;
			HRDATA   <= '0;
			waitLeft <= 0;
		end else if (HTRANS == transNonSeq) begin
			w = $urandom % 4;  // 0 to 3 wait states
			addrQ <= HADDR;
			if (w == 0) begin
				HREADY <= 1'b1;
				HRDATA <= {HADDR[31:16] ^ HADDR[15:0], words[HADDR[5:2]]};
			end else begin
				HREADY   <= 1'b0;
				waitLeft <= w;
			end
		end else if (waitLeft == 1) begin
			HREADY   <= 1'b1;
			HRDATA   <= {addrQ[31:16] ^ addrQ[15:0], words[addrQ[5:2]]};
			waitLeft <= 0;
		end else if (waitLeft > 1) begin
			waitLeft <= waitLeft - 1;
		end
	end

endmodule

module buzzerTb
	import buzzerPkg::*;
;

	localparam int     beatUnit = 16;
	localparam int     toneUnit = 4;
	localparam busAddr bgmBase  = 32'h0000_0100;
	localparam busAddr sfxBase  = 32'h0000_0240;

	logic     clk, rst_n, HSEL, HWRITE, HREADYOUT, PWM, BeatFinIRQ;
	transCode HTRANS, bgmHTRANS, sfxHTRANS;
	busAddr   HADDR, bgmHADDR, sfxHADDR;
	busData   HWDATA, HRDATA, bgmHRDATA, sfxHRDATA, d;
	logic     bgmHWRITE, sfxHWRITE, bgmHREADY, sfxHREADY;
	logic [1:0] HRESP;
	int       n;

	clockGen clkGen (.clk, .rst_n);

	Buzzer #(.beatUnit(beatUnit), .toneUnit(toneUnit)) Buzzer_inst (
		.clk, .rst_n, .HSEL, .HREADY(1'b1), .HWRITE, .HTRANS, .HADDR, .HWDATA,
		.HRDATA, .HREADYOUT, .HRESP,
		.bgmHADDR, .bgmHTRANS, .bgmHWRITE, .bgmHRDATA, .bgmHREADY,
		.sfxHADDR, .sfxHTRANS, .sfxHWRITE, .sfxHRDATA, .sfxHREADY,
		.PWM, .BeatFinIRQ
	);

	noteMemory bgmMem (.clk, .rst_n, .HADDR(bgmHADDR), .HTRANS(bgmHTRANS),
		.HREADY(bgmHREADY), .HRDATA(bgmHRDATA));
	noteMemory sfxMem (.clk, .rst_n, .HADDR(sfxHADDR), .HTRANS(sfxHTRANS),
		.HREADY(sfxHREADY), .HRDATA(sfxHRDATA));

	buzzerChecker #(.beatUnit(beatUnit), .toneUnit(toneUnit)) chk (
		.clk, .rst_n, .HSEL, .HWRITE, .HTRANS, .HADDR, .HWDATA,
		.bgmHADDR, .bgmHTRANS, .bgmHWRITE, .bgmHRDATA, .bgmHREADY,
		.sfxHADDR, .sfxHTRANS, .sfxHWRITE, .sfxHRDATA, .sfxHREADY,
		.PWM, .BeatFinIRQ
	);

	// tune 0 to 15, beat 1 to 4
	function automatic noteWord randomNote();
		return {4'h0, 4'($urandom % 4 + 1), 8'($urandom % 16)};
	endfunction

	task abortRun(input string why);
		$display("run aborted: %s", why);
		$display(">>> FAIL");
		$finish;
	endtask

	task writeReg(input regOffset off, input busData data);
		@(posedge clk);
		HSEL   <= 1'b1;
		HWRITE <= 1'b1;
		HTRANS <= transNonSeq;
		HADDR  <= {28'h0, off};
		@(posedge clk);
		HSEL   <= 1'b0;
		HTRANS <= transIdle;
		HWDATA <= data;
		@(posedge clk);
	endtask

	task readReg(input regOffset off, output busData data);
		@(posedge clk);
		HSEL   <= 1'b1;
		HWRITE <= 1'b0;
		HTRANS <= transNonSeq;
		HADDR  <= {28'h0, off};
		@(posedge clk);
		HSEL   <= 1'b0;
		HTRANS <= transIdle;
		@(negedge clk);
		data = HRDATA;
		chk.compareValue("HREADYOUT", 32'd1, 32'(HREADYOUT));
		chk.compareValue("HRESP", 32'd0, 32'(HRESP));
	endtask

	task waitStartHits(input int target, input int limit);
		n = 0;
		while (chk.startHits < target) begin
			if (++n > limit)
				abortRun("background score never came back to its start address");
			@(posedge clk);
		end
	endtask

	initial begin
		void'($urandom(32'hd0ca_81d6));
		HSEL   = 1'b0;
		HWRITE = 1'b0;
		HTRANS = transIdle;
		HADDR  = '0;
		HWDATA = '0;
		for (int i = 0; i < 16; i++) begin
			bgmMem.words[i] = (i < 4) ? randomNote() : 16'h0000;
			sfxMem.words[i] = (i < 3) ? randomNote() : 16'h0000;
		end
		bgmMem.words[2][7:0] = 8'h00;  // one rest in the background score
		n = 0;
		while (rst_n !== 1'b1) begin
			if (++n > 20)
				abortRun("reset never released");
			@(posedge clk);
		end

		chk.beginTest("registers");
		writeReg(regBgmStart, bgmBase);
		writeReg(regSfxStart, sfxBase);
		writeReg(regCtrl, 32'h2);
		readReg(regBgmStart, d);
		chk.compareValue("bgm start", bgmBase, d);
		readReg(regSfxStart, d);
		chk.compareValue("sfx start", sfxBase, d);
		readReg(regCtrl, d);
		chk.compareValue("ctrl", 32'h2, d);
		readReg(regStatus, d);
		chk.compareValue("status", 32'h0, d);
		chk.endTest();

		chk.beginTest("cyclic background");
		writeReg(regCtrl, 32'h3);
		readReg(regStatus, d);
		chk.compareValue("status", 32'h1, d);
		waitStartHits(2, 4000);  // wrapped once
		chk.endTest();

		chk.beginTest("sound effect priority");
		n = chk.fetchCount[0];
		writeReg(regCtrl, 32'ha);
		readReg(regStatus, d);
		chk.compareValue("status", 32'h3, d);
		for (int k = 0; d[1]; k++) begin
			if (k > 2000)
				abortRun("sound effect never finished");
			readReg(regStatus, d);
		end
		chk.compareValue("bgm fetched during sfx", 32'd1, 32'(chk.fetchCount[0] > n));
		chk.compareValue("status after sfx", 32'h1, d);
		waitStartHits(chk.startHits + 1, 4000);
		chk.endTest();

		chk.beginTest("background stop");
		writeReg(regCtrl, 32'h4);
		readReg(regStatus, d);
		chk.compareValue("status", 32'h0, d);
		chk.endTest();

		$display("%0d tests, %0d errors", chk.testCount, chk.errCount);
		if (chk.errCount == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: all.f
common/buzzerPkg.sv
common/noteFetchIf.sv
common/toneIf.sv
src/buzzerRegs.sv
voice/voiceCtrl.sv
voice/noteFetch.sv
voice/toneGen.sv
src/Buzzer.sv
test/clockGen.sv
test/buzzerChecker.sv
test/buzzerTb.sv

// File: Bender.yml
package:
  name: buzzer

sources:
  - common/buzzerPkg.sv
  - common/noteFetchIf.sv
  - common/toneIf.sv
  - src/buzzerRegs.sv
  - voice/voiceCtrl.sv
  - voice/noteFetch.sv
  - voice/toneGen.sv
  - src/Buzzer.sv
  - target: test
    files:
      - test/clockGen.sv
      - test/buzzerChecker.sv
      - test/buzzerTb.sv
